//--- verilog/sbuf_pkg.sv
package sbuf_pkg;

    parameter int addr_w = 32;
    parameter int data_w = 32;
    parameter int tag_w  = 16;

    typedef enum logic [1:0] {
        op_sb = 2'd0,
        op_sh = 2'd1,
        op_sw = 2'd2
    } store_op_e;  // Matches funct3

    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd4,
        op_lhu = 3'd5
    } load_op_e;

    typedef enum logic [1:0] {
        fwd_miss    = 2'd0,
        fwd_hit     = 2'd1,
        fwd_partial = 2'd2
    } fwd_result_e;

    typedef enum logic [1:0] {
        drain_idle = 2'd0,
        drain_send = 2'd1,
        drain_free = 2'd2
    } drain_state_e;

endpackage

//--- verilog/sbuf_drain_if.sv
`timescale 1ns/100ps

interface sbuf_drain_if #(
    parameter int DEPTH = 8
);
    localparam int IDX_W = $clog2(DEPTH);

    logic                        cand_valid;
    logic [sbuf_pkg::addr_w-1:0] cand_addr;   // Word aligned
    logic [sbuf_pkg::data_w-1:0] cand_data;
    logic [3:0]                  cand_strb;
    logic [IDX_W-1:0]            cand_index;
    logic                        release_valid;  // Entry leaves the buffer
    logic [IDX_W-1:0]            release_index;

    modport entries (
        output cand_valid, cand_addr, cand_data, cand_strb, cand_index,
        input  release_valid, release_index
    );

    modport drain (
        input  cand_valid, cand_addr, cand_data, cand_strb, cand_index,
        output release_valid, release_index
    );
endinterface

//--- verilog/sbuf_entries.sv
`timescale 1ns/100ps

module sbuf_entries #(
    parameter int DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        store_valid,
    input  logic                        store_ready,
    input  logic [sbuf_pkg::tag_w-1:0]  store_tag,
    input  logic [sbuf_pkg::addr_w-1:0] store_addr,
    input  logic [sbuf_pkg::data_w-1:0] store_data,
    input  sbuf_pkg::store_op_e         store_op,
    input  logic                        load_valid,
    input  logic [sbuf_pkg::tag_w-1:0]  load_tag,
    input  logic [sbuf_pkg::addr_w-1:0] load_addr,
    input  sbuf_pkg::load_op_e          load_op,
    output logic                        load_done,
    output sbuf_pkg::fwd_result_e       load_result,
    output logic [sbuf_pkg::data_w-1:0] load_data,
    output logic [3:0]                  load_mask,
    input  logic                        commit_valid,
    input  logic [sbuf_pkg::tag_w-1:0]  commit_tag,
    input  logic                        flush,
    sbuf_drain_if.entries               drain,
    output logic                        alloc,
    output logic [$clog2(DEPTH+1)-1:0]  dealloc_count
);
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int WA_W  = sbuf_pkg::addr_w - 2;

    logic [DEPTH-1:0]            ent_valid;
    logic [DEPTH-1:0]            ent_comm;
    logic [sbuf_pkg::tag_w-1:0]  ent_tag  [DEPTH];
    logic [WA_W-1:0]             ent_addr [DEPTH];
    logic [sbuf_pkg::data_w-1:0] ent_data [DEPTH];
    logic [3:0]                  ent_mask [DEPTH];

    logic [DEPTH-1:0]            keep;  // Committed after this edge
    logic [3:0]                  st_mask;
    logic [sbuf_pkg::data_w-1:0] st_lanes;
    logic                        store_take;
    logic                        merge_found;
    logic [IDX_W-1:0]            merge_idx;
    logic [IDX_W-1:0]            free_idx;
    logic [IDX_W-1:0]            wr_idx;
    logic                        best_found;
    logic [IDX_W-1:0]            best_idx;
    logic [sbuf_pkg::tag_w-1:0]  best_tag;
    logic                        ld_found;
    logic [IDX_W-1:0]            ld_idx;
    logic [sbuf_pkg::tag_w-1:0]  ld_tag;
    logic [3:0]                  ld_need;
    logic [3:0]                  ld_present;
    logic [sbuf_pkg::data_w-1:0] ld_word;
    logic [7:0]                  ld_byte;
    logic [15:0]                 ld_half;
    logic [sbuf_pkg::data_w-1:0] ld_ext;

    always_comb begin
        case (store_op)
            sbuf_pkg::op_sb: begin
                st_mask  = 4'b0001 << store_addr[1:0];
                st_lanes = {4{store_data[7:0]}};
            end
            sbuf_pkg::op_sh: begin
                st_mask  = 4'b0011 << {store_addr[1], 1'b0};
                st_lanes = {2{store_data[15:0]}};
            end
            default: begin
                st_mask  = 4'b1111;
                st_lanes = store_data;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++)
            keep[i] = ent_comm[i] | (commit_valid && ent_tag[i] <= commit_tag);
    end

    // Downward scan leaves the lowest index in place
    always_comb begin
        merge_found = 1'b0;
        merge_idx   = '0;
        free_idx    = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i])
                free_idx = IDX_W'(i);
            if (ent_valid[i] && !keep[i] && ent_addr[i] == store_addr[sbuf_pkg::addr_w-1:2]) begin
                merge_found = 1'b1;
                merge_idx   = IDX_W'(i);
            end
        end
    end

    assign store_take = store_valid && store_ready && !flush;  // Flush drops it
    assign alloc      = store_take && !merge_found;
    assign wr_idx     = merge_found ? merge_idx : free_idx;

    always_comb begin
        dealloc_count = drain.release_valid ? CNT_W'(1) : '0;
        for (int i = 0; i < DEPTH; i++)
            if (flush && ent_valid[i] && !keep[i])
                dealloc_count = dealloc_count + CNT_W'(1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_comm  <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (ent_valid[i] && keep[i])
                    ent_comm[i] <= 1'b1;
                if (flush && !keep[i])
                    ent_valid[i] <= 1'b0;
            end
            if (drain.release_valid) begin
                ent_valid[drain.release_index] <= 1'b0;
                ent_comm[drain.release_index]  <= 1'b0;
            end
            if (alloc) begin
                ent_valid[free_idx] <= 1'b1;
                ent_comm[free_idx]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_take) begin
            ent_tag[wr_idx]  <= store_tag;
            ent_addr[wr_idx] <= store_addr[sbuf_pkg::addr_w-1:2];
            ent_mask[wr_idx] <= merge_found ? (ent_mask[wr_idx] | st_mask) : st_mask;
            for (int b = 0; b < 4; b++)
                if (st_mask[b])
                    ent_data[wr_idx][8*b +: 8] <= st_lanes[8*b +: 8];
        end
    end

    // Oldest committed entry, skipping the one leaving now
    always_comb begin
        best_found = 1'b0;
        best_idx   = '0;
        best_tag   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_valid[i] && ent_comm[i]
                    && !(drain.release_valid && drain.release_index == IDX_W'(i))
                    && (!best_found || ent_tag[i] < best_tag)) begin
                best_found = 1'b1;
                best_idx   = IDX_W'(i);
                best_tag   = ent_tag[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            drain.cand_valid <= 1'b0;
        else
            drain.cand_valid <= best_found;
    end

    always_ff @(posedge clk) begin
        drain.cand_index <= best_idx;
        drain.cand_addr  <= {ent_addr[best_idx], 2'b00};
        drain.cand_data  <= ent_data[best_idx];
        drain.cand_strb  <= ent_mask[best_idx];
    end

    // Youngest older store to the same word
    always_comb begin
        ld_found = 1'b0;
        ld_idx   = '0;
        ld_tag   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_valid[i] && ent_addr[i] == load_addr[sbuf_pkg::addr_w-1:2]
                    && ent_tag[i] < load_tag && (!ld_found || ent_tag[i] > ld_tag)) begin
                ld_found = 1'b1;
                ld_idx   = IDX_W'(i);
                ld_tag   = ent_tag[i];
            end
        end
    end

    always_comb begin
        case (load_op)
            sbuf_pkg::op_lb, sbuf_pkg::op_lbu: ld_need = 4'b0001 << load_addr[1:0];
            sbuf_pkg::op_lh, sbuf_pkg::op_lhu: ld_need = 4'b0011 << {load_addr[1], 1'b0};
            default:                           ld_need = 4'b1111;
        endcase
        ld_present = ld_found ? (ld_need & ent_mask[ld_idx]) : 4'b0000;
        ld_word    = ent_data[ld_idx];
        ld_byte    = 8'(ld_word >> {load_addr[1:0], 3'b000});
        ld_half    = 16'(ld_word >> {load_addr[1], 4'b0000});
        case (load_op)
            sbuf_pkg::op_lb:  ld_ext = {{24{ld_byte[7]}}, ld_byte};
            sbuf_pkg::op_lbu: ld_ext = {24'd0, ld_byte};
            sbuf_pkg::op_lh:  ld_ext = {{16{ld_half[15]}}, ld_half};
            sbuf_pkg::op_lhu: ld_ext = {16'd0, ld_half};
            default:          ld_ext = ld_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            load_done <= 1'b0;
        else
            load_done <= load_valid;
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            load_mask <= ld_present;
            load_data <= ld_ext;
            if (ld_present == 4'b0000)
                load_result <= sbuf_pkg::fwd_miss;
            else if (ld_present == ld_need)
                load_result <= sbuf_pkg::fwd_hit;
            else
                load_result <= sbuf_pkg::fwd_partial;
        end
    end

endmodule

//--- verilog/sbuf_drain_fsm.sv
`timescale 1ns/100ps

module sbuf_drain_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    sbuf_drain_if.drain                 drain,
    output logic                        mem_valid,
    input  logic                        mem_ready,
    output logic [sbuf_pkg::addr_w-1:0] mem_addr,
    output logic [sbuf_pkg::data_w-1:0] mem_data,
    output logic [3:0]                  mem_strb
);
    sbuf_pkg::drain_state_e state;
    sbuf_pkg::drain_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            sbuf_pkg::drain_idle: begin
                if (drain.cand_valid)
                    state_next = sbuf_pkg::drain_send;
            end
            sbuf_pkg::drain_send: begin
                if (mem_ready)
                    state_next = sbuf_pkg::drain_free;
            end
            sbuf_pkg::drain_free: begin
                state_next = sbuf_pkg::drain_idle;  // Entry cleared at this edge
            end
            default: begin
                state_next = sbuf_pkg::drain_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= sbuf_pkg::drain_idle;
        else
            state <= state_next;
    end

    // Latched once per entry, held through the whole handshake
    always_ff @(posedge clk) begin
        if (state == sbuf_pkg::drain_idle && drain.cand_valid) begin
            mem_addr            <= drain.cand_addr;
            mem_data            <= drain.cand_data;
            mem_strb            <= drain.cand_strb;
            drain.release_index <= drain.cand_index;
        end
    end

    assign mem_valid           = (state == sbuf_pkg::drain_send);
    assign drain.release_valid = (state == sbuf_pkg::drain_free);

endmodule

//--- verilog/sbuf_occupancy.sv
`timescale 1ns/100ps

module sbuf_occupancy #(
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       alloc,
    input  logic [$clog2(DEPTH+1)-1:0] dealloc_count,
    output logic                       store_ready
);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0] count;  // Occupied entries

    always_ff @(posedge clk) begin
        if (!rst_n)
            count <= '0;
        else
            count <= count + CNT_W'(alloc) - dealloc_count;
    end

    // Low when full, merges included
    assign store_ready = (count != CNT_W'(DEPTH));

endmodule

//--- verilog/sbuf_top.sv
`timescale 1ns/100ps

module sbuf_top #(
    parameter int DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        store_valid,
    output logic                        store_ready,
    input  logic [sbuf_pkg::tag_w-1:0]  store_tag,
    input  logic [sbuf_pkg::addr_w-1:0] store_addr,
    input  logic [sbuf_pkg::data_w-1:0] store_data,
    input  sbuf_pkg::store_op_e         store_op,
    input  logic                        load_valid,
    input  logic [sbuf_pkg::tag_w-1:0]  load_tag,
    input  logic [sbuf_pkg::addr_w-1:0] load_addr,
    input  sbuf_pkg::load_op_e          load_op,
    output logic                        load_done,
    output sbuf_pkg::fwd_result_e       load_result,
    output logic [sbuf_pkg::data_w-1:0] load_data,
    output logic [3:0]                  load_mask,
    input  logic                        commit_valid,
    input  logic [sbuf_pkg::tag_w-1:0]  commit_tag,
    input  logic                        flush,
    output logic                        mem_valid,
    input  logic                        mem_ready,
    output logic [sbuf_pkg::addr_w-1:0] mem_addr,
    output logic [sbuf_pkg::data_w-1:0] mem_data,
    output logic [3:0]                  mem_strb
);
    logic                       alloc;
    logic [$clog2(DEPTH+1)-1:0] dealloc_count;

    sbuf_drain_if #(.DEPTH(DEPTH)) drain_bus ();

    sbuf_entries #(.DEPTH(DEPTH)) u_entries (
        .clk           (clk),
        .rst_n         (rst_n),
        .store_valid   (store_valid),
        .store_ready   (store_ready),
        .store_tag     (store_tag),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .store_op      (store_op),
        .load_valid    (load_valid),
        .load_tag      (load_tag),
        .load_addr     (load_addr),
        .load_op       (load_op),
        .load_done     (load_done),
        .load_result   (load_result),
        .load_data     (load_data),
        .load_mask     (load_mask),
        .commit_valid  (commit_valid),
        .commit_tag    (commit_tag),
        .flush         (flush),
        .drain         (drain_bus.entries),
        .alloc         (alloc),
        .dealloc_count (dealloc_count)
    );

    sbuf_drain_fsm u_drain_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .drain     (drain_bus.drain),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_strb  (mem_strb)
    );

    sbuf_occupancy #(.DEPTH(DEPTH)) u_occupancy (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc         (alloc),
        .dealloc_count (dealloc_count),
        .store_ready   (store_ready)
    );

endmodule

//--- bench/sbuf_assertions.sv
`timescale 1ns/100ps

module sbuf_assertions #(
    parameter int DEPTH       = 8,
    parameter bit CHECK_COUNT = 1'b1
) (
    input logic        clk,
    input logic        rst_n,
    input logic [5:0]  count,
    input logic        mem_valid,
    input logic        mem_ready,
    input logic [31:0] mem_addr,
    input logic [31:0] mem_data,
    input logic [3:0]  mem_strb,
    input logic        release_valid
);
    if (CHECK_COUNT) begin : g_count
        count_limit: assert property (@(posedge clk) disable iff (!rst_n)
            count <= 6'(DEPTH))
            else $error("occupancy count above DEPTH");
    end else begin : g_mem
        // Fields frozen while the write waits
        mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
            mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
                && $stable(mem_data) && $stable(mem_strb))
            else $error("mem channel changed before mem_ready");
        release_next: assert property (@(posedge clk) disable iff (!rst_n)
            mem_valid && mem_ready |=> release_valid)
            else $error("no release one cycle after mem handshake");
    end
endmodule

bind sbuf_occupancy sbuf_assertions #(.DEPTH(DEPTH), .CHECK_COUNT(1'b1)) count_checks (
    .clk(clk), .rst_n(rst_n), .count(6'(count)), .mem_valid(1'b0), .mem_ready(1'b0),
    .mem_addr(32'd0), .mem_data(32'd0), .mem_strb(4'd0), .release_valid(1'b0)
);

bind sbuf_drain_fsm sbuf_assertions #(.CHECK_COUNT(1'b0)) mem_checks (
    .clk(clk), .rst_n(rst_n), .count(6'd0), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_data(mem_data), .mem_strb(mem_strb),
    .release_valid(drain.release_valid)
);

//--- bench/sbuf_tb.sv
`timescale 1ns/100ps

module sbuf_tb;
    localparam int DEPTH = 8;
    localparam int LIMIT = 4 * 1200;  // Test length times four

    typedef struct packed {
        sbuf_pkg::fwd_result_e res;
        logic [31:0]           data;
        logic [3:0]            mask;
    } exp_t;

    logic clk, rst_n, store_valid, store_ready, load_valid, load_done;
    logic commit_valid, flush, mem_valid, mem_ready, mem_block;
    logic [15:0] store_tag, load_tag, commit_tag, next_tag;
    logic [sbuf_pkg::addr_w-1:0] store_addr, load_addr, mem_addr;
    logic [31:0] store_data, load_data, mem_data;
    logic [3:0]  load_mask, mem_strb;
    sbuf_pkg::store_op_e   store_op;
    sbuf_pkg::load_op_e    load_op;
    sbuf_pkg::fwd_result_e load_result;
    sbuf_pkg::load_op_e    lops [5] = '{sbuf_pkg::op_lb, sbuf_pkg::op_lh, sbuf_pkg::op_lw,
                                        sbuf_pkg::op_lbu, sbuf_pkg::op_lhu};
    integer seed = 58;
    int     cycles = 0;

    // Shadow of the entry array
    logic        m_valid [DEPTH];
    logic        m_comm  [DEPTH];
    logic [15:0] m_tag   [DEPTH];
    logic [31:0] m_addr  [DEPTH];
    logic [31:0] m_data  [DEPTH];
    logic [3:0]  m_mask  [DEPTH];
    logic        rel_pend;
    int          rel_idx;
    logic [7:0]  mem_bytes [int];
    logic [7:0]  exp_bytes [int];  // Committed bytes in tag order
    exp_t        exp_q [$];

    sbuf_top #(.DEPTH(DEPTH)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic int model_count();
        int n = 0;
        for (int i = 0; i < DEPTH; i++)
            if (m_valid[i])
                n++;
        return n;
    endfunction

    function automatic logic [3:0] lanes_of(input logic [31:0] a, input int size);
        if (size == 1)
            return 4'b0001 << a[1:0];
        else if (size == 2)
            return 4'b0011 << {a[1], 1'b0};
        return 4'b1111;
    endfunction

    // Address of the first byte where memory differs, or -1
    function automatic int first_mem_mismatch();
        foreach (exp_bytes[ad])
            if (!mem_bytes.exists(ad) || mem_bytes[ad] !== exp_bytes[ad])
                return ad;
        foreach (mem_bytes[ad])
            if (!exp_bytes.exists(ad))
                return ad;
        return -1;
    endfunction

    // Load rules applied to the shadow entries
    function automatic void ref_load(input logic [15:0] tag, input logic [31:0] addr,
                                     input sbuf_pkg::load_op_e op, output exp_t e);
        logic       found;
        int         sel;
        logic [3:0] need;
        logic [7:0] b;
        logic [15:0] h;
        found = 1'b0;
        sel   = 0;
        for (int i = 0; i < DEPTH; i++)
            if (m_valid[i] && m_addr[i] == {addr[31:2], 2'b00} && m_tag[i] < tag
                    && (!found || m_tag[i] > m_tag[sel])) begin
                found = 1'b1;
                sel   = i;
            end
        if (op == sbuf_pkg::op_lb || op == sbuf_pkg::op_lbu)
            need = lanes_of(addr, 1);
        else if (op == sbuf_pkg::op_lh || op == sbuf_pkg::op_lhu)
            need = lanes_of(addr, 2);
        else
            need = 4'b1111;
        e.mask = found ? (need & m_mask[sel]) : 4'b0000;
        b = m_data[sel][32'(addr[1:0]) * 8 +: 8];
        h = m_data[sel][32'(addr[1]) * 16 +: 16];
        case (op)
            sbuf_pkg::op_lb:  e.data = {{24{b[7]}}, b};
            sbuf_pkg::op_lbu: e.data = {24'd0, b};
            sbuf_pkg::op_lh:  e.data = {{16{h[15]}}, h};
            sbuf_pkg::op_lhu: e.data = {16'd0, h};
            default:          e.data = m_data[sel];
        endcase
        if (e.mask == 4'b0000)
            e.res = sbuf_pkg::fwd_miss;
        else if (e.mask == need)
            e.res = sbuf_pkg::fwd_hit;
        else
            e.res = sbuf_pkg::fwd_partial;
    endfunction

    // Checks and model update, sampled mid-cycle
    always @(negedge clk) begin
        exp_t       e;
        logic       keep [DEPTH];
        int         merge, free, best, size;
        logic [3:0] sm;
        logic [31:0] lm;
        if (rst_n) begin
            if (load_done) begin
                assert (exp_q.size() > 0) else stop_run("load_done with no load pending");
                e = exp_q.pop_front();
                assert (load_result == e.res) else stop_run($sformatf(
                    "** Error: load_result expected %h actual %h", e.res, load_result));
                assert (load_mask == e.mask) else stop_run($sformatf(
                    "** Error: load_mask expected %h actual %h", e.mask, load_mask));
                assert (e.res != sbuf_pkg::fwd_hit || load_data == e.data) else stop_run(
                    $sformatf("** Error: load_data expected %h actual %h", e.data, load_data));
            end
            if (load_valid) begin
                ref_load(load_tag, load_addr, load_op, e);
                exp_q.push_back(e);
            end
            assert (store_ready == (model_count() != DEPTH)) else stop_run($sformatf(
                "** Error: store_ready expected %h actual %h", model_count() != DEPTH,
                store_ready));
            best = -1;
            if (mem_valid && mem_ready) begin
                for (int i = 0; i < DEPTH; i++)
                    if (m_valid[i] && m_comm[i] && !(rel_pend && rel_idx == i)
                            && (best < 0 || m_tag[i] < m_tag[best]))
                        best = i;
                assert (best >= 0) else stop_run("memory write with no committed store left");
                lm = {{8{mem_strb[3]}}, {8{mem_strb[2]}}, {8{mem_strb[1]}}, {8{mem_strb[0]}}};
                assert (mem_addr == m_addr[best]) else stop_run($sformatf(
                    "** Error: mem_addr expected %h actual %h", m_addr[best], mem_addr));
                assert (mem_strb == m_mask[best]) else stop_run($sformatf(
                    "** Error: mem_strb expected %h actual %h", m_mask[best], mem_strb));
                assert ((mem_data & lm) == (m_data[best] & lm)) else stop_run($sformatf(
                    "** Error: mem_data expected %h actual %h", m_data[best] & lm,
                    mem_data & lm));
                for (int b = 0; b < 4; b++)
                    if (mem_strb[b])
                        mem_bytes[int'(mem_addr) + b] = mem_data[8*b +: 8];
            end
            merge = -1;
            free  = -1;
            for (int i = 0; i < DEPTH; i++) begin
                keep[i] = m_comm[i] || (commit_valid && m_tag[i] <= commit_tag);
                if (!m_valid[i] && free < 0)
                    free = i;
                if (m_valid[i] && !keep[i] && m_addr[i] == {store_addr[31:2], 2'b00}
                        && merge < 0)
                    merge = i;
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (m_valid[i] && keep[i] && !m_comm[i])
                    for (int b = 0; b < 4; b++)
                        if (m_mask[i][b])
                            exp_bytes[int'(m_addr[i]) + b] = m_data[i][8*b +: 8];
                if (m_valid[i] && keep[i])
                    m_comm[i] = 1'b1;
                if (flush && !keep[i])
                    m_valid[i] = 1'b0;
            end
            if (rel_pend) begin
                m_valid[rel_idx] = 1'b0;
                m_comm[rel_idx]  = 1'b0;
                rel_pend         = 1'b0;
            end
            if (best >= 0) begin
                rel_pend = 1'b1;
                rel_idx  = best;
            end
            if (store_valid && store_ready && !flush) begin
                size = (store_op == sbuf_pkg::op_sb) ? 1 : (store_op == sbuf_pkg::op_sh) ? 2 : 4;
                sm   = lanes_of(store_addr, size);
                if (merge < 0) begin
                    merge           = free;
                    m_valid[merge]  = 1'b1;
                    m_comm[merge]   = 1'b0;
                    m_mask[merge]   = 4'b0000;
                end
                m_tag[merge]  = store_tag;
                m_addr[merge] = {store_addr[31:2], 2'b00};
                m_mask[merge] = m_mask[merge] | sm;
                for (int b = 0; b < 4; b++)
                    if (sm[b])
                        m_data[merge][8*b +: 8] = (size == 1) ? store_data[7:0]
                            : (size == 2) ? store_data[8*(b%2) +: 8] : store_data[8*b +: 8];
            end
        end
    end

    // Memory side with random back-pressure
    initial begin
        int r;
        mem_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #10;
            r = $random(seed);
            mem_ready = mem_block ? 1'b0 : (r[0] | r[1]);
        end
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        stop_run("Timeout: the test did not finish within the cycle limit");
    end

    task automatic tick();
        @(posedge clk);
        #10;
        load_valid   = 1'b0;
        commit_valid = 1'b0;
        flush        = 1'b0;
    endtask

    task automatic send_store(input logic [31:0] addr, input logic [31:0] data,
                              input sbuf_pkg::store_op_e op);
        store_valid = 1'b1;
        store_tag   = next_tag;
        store_addr  = addr;
        store_data  = data;
        store_op    = op;
        while (!store_ready)
            tick();
        tick();
        store_valid = 1'b0;
        next_tag    = next_tag + 16'd1;
    endtask

    task automatic probe_load(input logic [31:0] addr, input sbuf_pkg::load_op_e op,
                              input logic [15:0] tag);
        load_valid = 1'b1;
        load_tag   = tag;
        load_addr  = addr;
        load_op    = op;
        tick();
    endtask

    task automatic commit_upto(input logic [15:0] tag);
        commit_valid = 1'b1;
        commit_tag   = tag;
        tick();
    endtask

    task automatic wait_empty();
        while (model_count() != 0 || exp_q.size() != 0)
            tick();
    endtask

    initial begin
        int r, w, k, bad;
        logic [31:0] a;
        rst_n        = 1'b0;
        store_valid  = 1'b0;
        load_valid   = 1'b0;
        commit_valid = 1'b0;
        flush        = 1'b0;
        mem_block    = 1'b0;
        store_tag    = '0;
        load_tag     = '0;
        commit_tag   = '0;
        store_addr   = '0;
        store_data   = '0;
        load_addr    = '0;
        store_op     = sbuf_pkg::op_sw;
        load_op      = sbuf_pkg::op_lw;
        next_tag     = 16'd1;
        rel_pend     = 1'b0;
        rel_idx      = 0;
        for (int i = 0; i < DEPTH; i++) begin
            m_valid[i] = 1'b0;
            m_comm[i]  = 1'b0;
        end
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
        tick();
        // Full-word forwarding with every load type
        send_store(32'h100, 32'h80F1_72A3, sbuf_pkg::op_sw);
        probe_load(32'h100, sbuf_pkg::op_lw, next_tag);
        probe_load(32'h102, sbuf_pkg::op_lh, next_tag);
        probe_load(32'h100, sbuf_pkg::op_lh, next_tag);
        probe_load(32'h103, sbuf_pkg::op_lb, next_tag);
        probe_load(32'h101, sbuf_pkg::op_lbu, next_tag);
        probe_load(32'h102, sbuf_pkg::op_lhu, next_tag);
        probe_load(32'h100, sbuf_pkg::op_lw, next_tag - 16'd1);  // Older than the store
        // Merge into one entry, then partial and byte hits
        send_store(32'h201, 32'h0000_00C5, sbuf_pkg::op_sb);
        send_store(32'h202, 32'h0000_9E11, sbuf_pkg::op_sh);
        probe_load(32'h200, sbuf_pkg::op_lw, next_tag);
        probe_load(32'h201, sbuf_pkg::op_lb, next_tag);
        commit_upto(next_tag - 16'd1);
        wait_empty();
        // Drain order against address order
        for (int i = 0; i < 6; i++)
            send_store(32'h3F0 - 32'(i * 16), 32'hA500_0000 + 32'(i), sbuf_pkg::op_sw);
        commit_upto(next_tag - 16'd3);
        commit_upto(next_tag - 16'd1);
        wait_empty();
        // Flush with a mix of committed and pending stores
        for (int i = 0; i < 4; i++)
            send_store(32'h500 + 32'(i * 4), 32'h5A5A_0000 + 32'(i), sbuf_pkg::op_sw);
        commit_upto(next_tag - 16'd3);
        flush = 1'b1;
        tick();
        for (int i = 0; i < 4; i++)
            probe_load(32'h500 + 32'(i * 4), sbuf_pkg::op_lw, next_tag);
        wait_empty();
        // Full buffer with memory stalled
        mem_block = 1'b1;
        for (int i = 0; i < DEPTH; i++)
            send_store(32'h600 + 32'(i * 4), 32'h6000_0000 + 32'(i), sbuf_pkg::op_sw);
        commit_upto(next_tag - 16'd1);
        assert (!store_ready) else stop_run($sformatf(
            "** Error: store_ready expected %h actual %h", 1'b0, store_ready));
        fork
            begin
                repeat (6) @(posedge clk);
                mem_block = 1'b0;
            end
        join_none
        send_store(32'h700, 32'h7777_0001, sbuf_pkg::op_sw);
        probe_load(32'h700, sbuf_pkg::op_lw, next_tag);
        commit_upto(next_tag - 16'd1);
        wait_empty();
        // Random traffic
        for (int n = 0; n < 400; n++) begin
            r = $random(seed);
            k = int'($unsigned(r) % 20);
            w = int'($unsigned(r >> 8) % 8);
            a = 32'h800 + 32'(w * 4) + 32'(r[17:16]);
            if (k < 8 && store_ready) begin
                if (r[20])
                    send_store({a[31:2], 2'b00}, $random(seed), sbuf_pkg::op_sw);
                else if (r[21])
                    send_store({a[31:1], 1'b0}, $random(seed), sbuf_pkg::op_sh);
                else
                    send_store(a, $random(seed), sbuf_pkg::op_sb);
            end else if (k < 14) begin
                load_op = lops[int'($unsigned(r >> 24) % 5)];
                if (load_op == sbuf_pkg::op_lw)
                    a = {a[31:2], 2'b00};
                else if (load_op == sbuf_pkg::op_lh || load_op == sbuf_pkg::op_lhu)
                    a = {a[31:1], 1'b0};
                probe_load(a, load_op, next_tag - 16'(r[23:22]));
            end else if (k < 19) begin
                commit_upto(next_tag - 16'd1 - 16'(r[27:26]));
            end else begin
                flush = 1'b1;
                tick();
            end
        end
        commit_upto(next_tag - 16'd1);
        wait_empty();
        repeat (3) tick();
        bad = first_mem_mismatch();
        if (bad < 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_run($sformatf("** Error: mem_data at %h expected %h actual %h", bad,
                exp_bytes.exists(bad) ? exp_bytes[bad] : 8'h00,
                mem_bytes.exists(bad) ? mem_bytes[bad] : 8'h00));
        end
    end
endmodule

//--- sbuf.f
verilog/sbuf_pkg.sv
verilog/sbuf_drain_if.sv
verilog/sbuf_entries.sv
verilog/sbuf_drain_fsm.sv
verilog/sbuf_occupancy.sv
verilog/sbuf_top.sv
bench/sbuf_assertions.sv
bench/sbuf_tb.sv

//--- Makefile
SRCS = $(wildcard verilog/*.sv bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vsbuf_tb

obj_dir/Vsbuf_tb: sbuf.f $(SRCS)
	verilator --binary --timing --assert --top-module sbuf_tb -f sbuf.f -o Vsbuf_tb

run: obj_dir/Vsbuf_tb
	./obj_dir/Vsbuf_tb | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
